/* logic/avalonRegs.sv */
// Avalon slave register file for the string accelerator
// Holds A, B, control and result, read latency of one cycle
// Turns an accepted go write into a start pulse and tracks done
`timescale 1ns/10ps

module avalonRegs
(
  input  logic        clk,
  input  logic        reset,
  input  logic        chipselect,
  input  logic        read,
  input  logic        write,
  input  logic [1:0]  address,
  input  logic [31:0] writedata,
  output logic [31:0] readdata,
  stringEngineIf.regs bus
);
  import stringPkg::*;

  // Host visible registers
  logic [31:0] regAVal;
  logic [31:0] regBVal;
  logic [31:0] resultReg;
  stringOp     opSel;
  logic [2:0]  lenField;
  logic        goFlag;
  logic        doneFlag;

  // Start pulse, high for the cycle after the go write
  logic        startQ;
  // Job in flight, includes the start cycle before busy rises
  logic        engineActive;
  logic [31:0] ctrlValue;
  logic [31:0] readMux;

  assign engineActive = bus.busy | startQ;

  // Job request toward the engine
  assign bus.start  = startQ;
  assign bus.op     = opSel;
  assign bus.length = lenField;
  assign bus.a      = regAVal;
  assign bus.b      = regBVal;

  // Control word as the host sees it
  always_comb
  begin
    ctrlValue = '0;
    ctrlValue[ctrlDoneBit] = doneFlag;
    ctrlValue[ctrlGoBit] = goFlag;
    ctrlValue[ctrlIndexLsb +: 3] = opSel;
    ctrlValue[ctrlLengthLsb +: 3] = lenField;
  end

  // Read data select
  always_comb
  begin
    case (address)
      regA:       readMux = regAVal;
      regB:       readMux = regBVal;
      regControl: readMux = ctrlValue;
      default:    readMux = resultReg;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      regAVal   <= '0;
      regBVal   <= '0;
      resultReg <= '0;
      opSel     <= opCompare;
      lenField  <= '0;
      goFlag    <= 1'b0;
      doneFlag  <= 1'b0;
      startQ    <= 1'b0;
      readdata  <= '0;
    end
    else
    begin
      startQ <= 1'b0;

      // Engine finished, capture result and flag done
      if (bus.finish)
      begin
        resultReg <= bus.result;
        doneFlag  <= 1'b1;
      end

      if (chipselect && write)
      begin
        case (address)
          regA:
          begin
            // Operands locked while a job runs
            if (!engineActive)
              regAVal <= writedata;
          end
          regB:
          begin
            if (!engineActive)
              regBVal <= writedata;
          end
          regControl:
          begin
            if (writedata[ctrlGoBit])
            begin
              // Go only when idle and the last done was acknowledged
              if (!engineActive && !doneFlag)
              begin
                opSel    <= stringOp'(writedata[ctrlIndexLsb +: 3]);
                lenField <= writedata[ctrlLengthLsb +: 3];
                goFlag   <= 1'b1;
                startQ   <= 1'b1;
              end
            end
            else
            begin
              // Go low acknowledges the job
              goFlag   <= 1'b0;
              doneFlag <= 1'b0;
            end
          end
          default:
          begin
            // Result is read-only
          end
        endcase
      end

      // Registered read, valid one cycle after the request
      if (chipselect && read)
        readdata <= readMux;
    end
  end

endmodule

/* logic/stringAccel.sv */
// String accelerator top level
// Avalon register block driving one serial character engine
`timescale 1ns/10ps

module stringAccel
(
  input  logic        clk,
  input  logic        reset,
  input  logic        chipselect,
  input  logic        read,
  input  logic        write,
  input  logic [1:0]  address,
  input  logic [31:0] writedata,
  output logic [31:0] readdata
);

  // Job link between registers and engine
  stringEngineIf engineBus ();

  // Host side registers
  avalonRegs regsInst
  (
    .clk        (clk),
    .reset      (reset),
    .chipselect (chipselect),
    .read       (read),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .readdata   (readdata),
    .bus        (engineBus)
  );

  // Character engine
  stringEngine engineInst
  (
    .clk   (clk),
    .reset (reset),
    .bus   (engineBus)
  );

endmodule

/* logic/stringEngine.sv */
// Serial character engine
// Compare, to-upper and to-lower over the low characters of A and B
// One character per cycle, then a single finish cycle
`timescale 1ns/10ps

module stringEngine
(
  input  logic clk,
  input  logic reset,
  stringEngineIf.engine bus
);
  import stringPkg::*;

  engineState  state;
  // Latched job
  stringOp     opQ;
  logic [31:0] work;
  logic [31:0] bQ;
  logic [1:0]  lastIdx;
  // Character being processed, 0 is bits 7:0
  logic [1:0]  charIdx;
  logic        matchQ;
  logic [7:0]  curA;
  logic [7:0]  curB;
  logic [2:0]  effLen;

  // Length of 0 or above a word means the whole word
  function automatic logic [2:0] effLength(input logic [2:0] len);
    if ((len == 3'd0) || (len > 3'(wordBytes)))
      return 3'(wordBytes);
    else
      return len;
  endfunction

  assign effLen = effLength(bus.length);

  // Current byte pair
  assign curA = work[charIdx*8 +: 8];
  assign curB = bQ[charIdx*8 +: 8];

  // Status toward the register block
  assign bus.busy   = (state != stIdle);
  assign bus.finish = (state == stDone);

  // Result select, only looked at during stDone
  always_comb
  begin
    case (opQ)
      opCompare: bus.result = {31'b0, matchQ};
      opToUpper: bus.result = work;
      opToLower: bus.result = work;
      default:   bus.result = '0;
    endcase
  end

  // Control FSM
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state   <= stIdle;
      charIdx <= '0;
    end
    else
    begin
      case (state)
        stIdle:
        begin
          if (bus.start)
          begin
            state   <= stRun;
            charIdx <= '0;
          end
        end
        stRun:
        begin
          // Step through the chars, stop after the last one
          if (charIdx == lastIdx)
            state <= stDone;
          else
            charIdx <= charIdx + 2'd1;
        end
        default:
        begin
          // Finish cycle, back to idle
          state <= stIdle;
        end
      endcase
    end
  end

  // Datapath, operands sampled only at start
  always_ff @(posedge clk)
  begin
    if ((state == stIdle) && bus.start)
    begin
      opQ     <= bus.op;
      work    <= bus.a;
      bQ      <= bus.b;
      lastIdx <= 2'(effLen - 3'd1);
      matchQ  <= 1'b1;
    end
    else if (state == stRun)
    begin
      case (opQ)
        opCompare:
        begin
          // First mismatch clears the flag for good
          if (curA != curB)
            matchQ <= 1'b0;
        end
        opToUpper:
        begin
          if ((curA >= "a") && (curA <= "z"))
            work[charIdx*8 +: 8] <= curA - 8'h20;
        end
        opToLower:
        begin
          if ((curA >= "A") && (curA <= "Z"))
            work[charIdx*8 +: 8] <= curA + 8'h20;
        end
        default:
        begin
          // Unused index, just walk the length
        end
      endcase
    end
  end

endmodule

/* logic/stringEngineIf.sv */
// Register block to engine link
// Carries the job operands out and the job result back
`timescale 1ns/10ps

interface stringEngineIf;
  import stringPkg::*;

  // Job request, driven by the register block
  logic        start;
  stringOp     op;
  logic [2:0]  length;
  logic [31:0] a;
  logic [31:0] b;

  // Job status and result, driven by the engine
  logic        busy;
  logic        finish;
  logic [31:0] result;

  modport regs (output start, op, length, a, b, input busy, finish, result);

  modport engine (input start, op, length, a, b, output busy, finish, result);

endinterface

/* logic/stringPkg.sv */
// String accelerator shared definitions
// Operation and engine state encodings, register map, control bit layout
package stringPkg;

  // Operation index as written into the control register
  typedef enum logic [2:0]
  {
    opCompare = 3'd0,
    opToUpper = 3'd1,
    opToLower = 3'd2
  } stringOp;

  // Engine FSM states
  typedef enum logic [1:0]
  {
    stIdle = 2'd0,
    stRun  = 2'd1,
    stDone = 2'd2
  } engineState;

  // Characters held in one 32-bit word
  localparam int wordBytes = 4;

  // Avalon register addresses
  localparam logic [1:0] regA       = 2'd0;
  localparam logic [1:0] regB       = 2'd1;
  localparam logic [1:0] regControl = 2'd2;
  localparam logic [1:0] regResult  = 2'd3;

  // Control register layout, [length, index, go, done]
  localparam int ctrlDoneBit   = 0;
  localparam int ctrlGoBit     = 1;
  localparam int ctrlIndexLsb  = 2;
  localparam int ctrlLengthLsb = 5;

endpackage

/* runSim.sh */
#!/bin/sh
# Build and run the string accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module stringAccelTb -f stringAccel.f \
  --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

/* stringAccel.f */
logic/stringPkg.sv
logic/stringEngineIf.sv
logic/avalonRegs.sv
logic/stringEngine.sv
logic/stringAccel.sv
tb/stringAccelTb.sv

/* tb/stringAccelTb.sv */
// Testbench for the string accelerator
// Table of jobs driven over the Avalon slave, results checked against a model
`timescale 1ns/10ps

module stringAccelTb;
  import stringPkg::*;

  localparam int numFixed = 12;
  localparam int numRows = numFixed + 8;
  localparam int timeoutCycles = numRows * 40 + 100;

  typedef struct packed
  {
    logic [2:0]  op;
    logic [2:0]  len;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
  } tableRow;

  logic        clk;
  logic        reset;
  logic        chipselect;
  logic        read;
  logic        write;
  logic [1:0]  address;
  logic [31:0] writedata;
  logic [31:0] readdata;

  tableRow     rows [numRows];
  integer      seed;
  integer      errors;
  integer      cycleCount;

  stringAccel DUT
  (
    .clk        (clk),
    .reset      (reset),
    .chipselect (chipselect),
    .read       (read),
    .write      (write),
    .address    (address),
    .writedata  (writedata),
    .readdata   (readdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit sized from the table length
  always @(posedge clk)
  begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= timeoutCycles)
    begin
      $display("Timeout after %0d cycles, the test did not complete", cycleCount);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // One host write bus cycle
  task automatic avWrite(input logic [1:0] addr, input logic [31:0] data);
    chipselect = 1'b1;
    write      = 1'b1;
    address    = addr;
    writedata  = data;
    @(posedge clk);
    #2;
    chipselect = 1'b0;
    write      = 1'b0;
  endtask

  // Host read with readdata registered at the request edge
  task automatic avRead(input logic [1:0] addr, output logic [31:0] data);
    chipselect = 1'b1;
    read       = 1'b1;
    address    = addr;
    @(posedge clk);
    #2;
    chipselect = 1'b0;
    read       = 1'b0;
    data       = readdata;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("error at %0t: %s expected %h actual %h", $time, name, exp, act);
      errors = errors + 1;
    end
  endtask

  // Poll the control register until done shows up
  task automatic waitDone(output logic ok);
    logic [31:0] v;
    int polls;
    ok = 1'b0;
    polls = 0;
    while (!ok && polls < 12)
    begin
      avRead(regControl, v);
      ok = v[ctrlDoneBit];
      polls++;
    end
    if (!ok)
    begin
      $display("Done bit never came up at %0t", $time);
      errors = errors + 1;
    end
  endtask

  function automatic logic [31:0] makeControl(input logic [2:0] op, input logic [2:0] len);
    logic [31:0] w;
    w = '0;
    w[ctrlGoBit] = 1'b1;
    w[ctrlIndexLsb +: 3] = op;
    w[ctrlLengthLsb +: 3] = len;
    return w;
  endfunction

  // Expected result straight from the operation rules
  function automatic logic [31:0] refModel(input logic [2:0] op, input logic [2:0] len,
                                           input logic [31:0] a, input logic [31:0] b);
    int n;
    logic [31:0] res;
    logic [7:0] c;
    logic same;
    n = ((len == 3'd0) || (len > 3'd4)) ? wordBytes : int'(len);
    res = a;
    same = 1'b1;
    for (int i = 0; i < n; i++)
    begin
      c = a[i*8 +: 8];
      if (c != b[i*8 +: 8])
        same = 1'b0;
      if ((op == opToUpper) && (c >= "a") && (c <= "z"))
        res[i*8 +: 8] = c - 8'h20;
      if ((op == opToLower) && (c >= "A") && (c <= "Z"))
        res[i*8 +: 8] = c + 8'h20;
    end
    if (op == opCompare)
      return {31'b0, same};
    else if ((op == opToUpper) || (op == opToLower))
      return res;
    else
      return '0;
  endfunction

  // Random char that is mostly a letter of either case and sometimes a digit
  function automatic logic [7:0] randChar();
    logic [31:0] r;
    logic [4:0] off;
    r = $random(seed);
    if (r[9:8] == 2'b00)
      return 8'h30 + {5'b0, r[2:0]};
    off = r[4:0] % 5'd26;
    return (r[6] ? 8'h61 : 8'h41) + {3'b0, off};
  endfunction

  task automatic setRow(input int idx, input logic [2:0] op, input logic [2:0] len,
                        input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
    rows[idx].op       = op;
    rows[idx].len      = len;
    rows[idx].a        = a;
    rows[idx].b        = b;
    rows[idx].expected = exp;
  endtask

  task automatic fillTable();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] m;
    setRow(0, opCompare, 3'd4, "abcd", "abca", 32'd0);
    setRow(1, opCompare, 3'd4, "abcd", "abcd", 32'd1);
    setRow(2, opToUpper, 3'd4, "abcd", 32'd0, "ABCD");
    setRow(3, opToUpper, 3'd2, {16'h0, "Ab"}, 32'd0, {16'h0, "AB"});
    setRow(4, opToLower, 3'd4, "ABCD", 32'd0, "abcd");
    setRow(5, opToLower, 3'd2, {16'h0, "Ab"}, 32'd0, {16'h0, "ab"});
    // Differs only in the top char outside length 3
    setRow(6, opCompare, 3'd3, "xbcd", "abcd", 32'd1);
    setRow(7, opToUpper, 3'd0, "ab1d", 32'd0, "AB1D");
    setRow(8, opToLower, 3'd1, "WXYZ", 32'd0, "WXYz");
    // Length 7 behaves as 4
    setRow(9, opToUpper, 3'd7, "a-Z?", 32'd0, "A-Z?");
    setRow(10, 3'd3, 3'd4, "abcd", "abcd", 32'd0);
    setRow(11, opCompare, 3'd0, "abcx", "abcd", 32'd0);
    for (int i = numFixed; i < numRows; i++)
    begin
      for (int k = 0; k < wordBytes; k++)
        a[k*8 +: 8] = randChar();
      r = $random(seed);
      m = $unsigned(r) % 32'd3;
      // Odd rows compare equal words and even rows get a new top char
      if (i % 2 == 1)
        b = a;
      else
        b = {randChar(), a[23:0]};
      setRow(i, m[2:0], r[10:8], a, b, refModel(m[2:0], r[10:8], a, b));
    end
  endtask

  task automatic runRow(input int idx);
    tableRow row;
    logic [31:0] v;
    logic ok;
    row = rows[idx];
    avWrite(regA, row.a);
    avWrite(regB, row.b);
    avRead(regA, v);
    checkValue("readdata (A)", row.a, v);
    avRead(regB, v);
    checkValue("readdata (B)", row.b, v);
    avWrite(regControl, makeControl(row.op, row.len));
    waitDone(ok);
    avRead(regResult, v);
    checkValue("readdata (result)", row.expected, v);
    // Acknowledge so done and go both clear
    avWrite(regControl, 32'd0);
    avRead(regControl, v);
    checkValue("readdata (control go/done)", 32'd0, {30'b0, v[ctrlGoBit], v[ctrlDoneBit]});
  endtask

  initial
  begin
    logic [31:0] v;
    logic ok;
    reset      = 1'b1;
    chipselect = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    address    = 2'd0;
    writedata  = 32'd0;
    seed       = 32'h3d00a185;
    errors     = 0;
    cycleCount = 0;
    fillTable();
    repeat (5) @(posedge clk);
    #2;
    reset = 1'b0;

    avRead(regControl, v);
    checkValue("readdata (control after reset)", 32'd0, v);

    for (int k = 0; k < numRows; k++)
      runRow(k);

    // A write right behind go lands while the job is in flight
    avWrite(regA, "abcd");
    avWrite(regControl, makeControl(opToUpper, 3'd4));
    avWrite(regA, "zzzz");
    waitDone(ok);
    // Second go while done is still set
    avWrite(regControl, makeControl(opToLower, 3'd4));
    idleCycles(6);
    avRead(regResult, v);
    checkValue("readdata (result after ignored go)", "ABCD", v);
    avRead(regA, v);
    checkValue("readdata (A after busy write)", "abcd", v);
    avRead(regControl, v);
    checkValue("readdata (control done)", 32'd1, {31'b0, v[ctrlDoneBit]});
    avWrite(regControl, 32'd0);

    $display("Checks complete, %0d errors", errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule
